// File: common/wallace_pkg.sv
package wallace_pkg;

    // Operand and product widths
    localparam int OP_W   = 16;
    localparam int PROD_W = 2 * OP_W;

    // Row counts at each reduction boundary
    localparam int PP_ROWS  = OP_W;
    localparam int MID_ROWS = 6;
    localparam int SUM_ROWS = 2;

    // Registers from operands to product
    localparam int PIPE_DEPTH = 4;

    typedef logic [OP_W-1:0]   operand_t;

    // One row, already shifted to its weight
    typedef logic [PROD_W-1:0] row_t;

endpackage

// File: source/pipe_ctrl.sv
module pipe_ctrl (
    input  logic clk,
    input  logic arst_n,
    input  logic in_valid,
    output logic load_pp,
    output logic load_mid,
    output logic load_sum,
    output logic load_out,
    output logic out_valid,
    output logic busy
);
    import wallace_pkg::*;

    // One flag per stage register, bit 0 is the partial-product stage
    logic [PIPE_DEPTH-1:0] valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[PIPE_DEPTH-2:0], in_valid};
        end
    end

    // Enable follows the item about to enter each register
    assign load_pp  = in_valid;
    assign load_mid = valid_q[0];
    assign load_sum = valid_q[1];
    assign load_out = valid_q[2];

    assign out_valid = valid_q[PIPE_DEPTH-1];
    assign busy      = |valid_q;

endmodule

// File: source/pp_gen.sv
module pp_gen (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  load_pp,
    input  wallace_pkg::operand_t a,
    input  wallace_pkg::operand_t b,
    output wallace_pkg::row_t     pp_rows [wallace_pkg::PP_ROWS]
);
    import wallace_pkg::*;

    row_t pp_d [PP_ROWS];

    // Row i is a gated by b[i], moved up to weight i
    always_comb begin
        for (int i = 0; i < PP_ROWS; i++) begin
            pp_d[i] = row_t'({{(PROD_W - OP_W){1'b0}}, a & {OP_W{b[i]}}}) << i;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < PP_ROWS; i++) begin
                pp_rows[i] <= '0;
            end
        end else if (load_pp) begin
            for (int i = 0; i < PP_ROWS; i++) begin
                pp_rows[i] <= pp_d[i];
            end
        end
    end

endmodule

// File: wallace/csa_reduce.sv
module csa_reduce #(
    parameter int IN_ROWS  = wallace_pkg::PP_ROWS,
    parameter int OUT_ROWS = wallace_pkg::SUM_ROWS
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              load,
    input  wallace_pkg::row_t rows_in  [IN_ROWS],
    output wallace_pkg::row_t rows_out [OUT_ROWS]
);
    import wallace_pkg::*;

    // Rows left after one level of 3:2 compression
    function automatic int rows_after(input int n);
        return (n / 3) * 2 + n % 3;
    endfunction

    function automatic int level_count(input int n_in, input int n_out);
        int n;
        int cnt;
        n   = n_in;
        cnt = 0;
        while (n > n_out) begin
            n   = rows_after(n);
            cnt = cnt + 1;
        end
        return cnt;
    endfunction

    // Bitwise half adder over a whole row, returns {carry, sum}
    function automatic logic [2*PROD_W-1:0] half_add(input row_t x, input row_t y);
        return {x & y, x ^ y};
    endfunction

    // Full adder as two half adders, carry not yet shifted
    function automatic logic [2*PROD_W-1:0] full_add(input row_t x, input row_t y,
                                                     input row_t z);
        logic [2*PROD_W-1:0] h1;
        logic [2*PROD_W-1:0] h2;
        h1 = half_add(x, y);
        h2 = half_add(h1[PROD_W-1:0], z);
        return {h1[2*PROD_W-1:PROD_W] | h2[2*PROD_W-1:PROD_W], h2[PROD_W-1:0]};
    endfunction

    localparam int NUM_LEVELS = level_count(IN_ROWS, OUT_ROWS);

    row_t reduced [OUT_ROWS];

    always_comb begin : reduce_levels
        row_t                work [IN_ROWS];
        row_t                next [IN_ROWS];
        logic [2*PROD_W-1:0] sc;
        int                  n;
        int                  groups;
        for (int r = 0; r < IN_ROWS; r++) begin
            work[r] = rows_in[r];
        end
        n  = IN_ROWS;
        sc = '0;
        for (int l = 0; l < NUM_LEVELS; l++) begin
            groups = n / 3;
            for (int r = 0; r < IN_ROWS; r++) begin
                next[r] = '0;
            end
            for (int g = 0; g < IN_ROWS / 3; g++) begin
                if (g < groups) begin
                    sc = full_add(work[3*g], work[3*g+1], work[3*g+2]);
                    next[2*g]   = sc[PROD_W-1:0];
                    // Carry moves up one weight, top bit falls off
                    next[2*g+1] = {sc[2*PROD_W-2:PROD_W], 1'b0};
                end
            end
            // Leftover rows go through untouched
            for (int r = 0; r < 2; r++) begin
                if (r < n % 3) begin
                    next[2*groups+r] = work[3*groups+r];
                end
            end
            work = next;
            n    = rows_after(n);
        end
        for (int r = 0; r < OUT_ROWS; r++) begin
            reduced[r] = work[r];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < OUT_ROWS; r++) begin
                rows_out[r] <= '0;
            end
        end else if (load) begin
            for (int r = 0; r < OUT_ROWS; r++) begin
                rows_out[r] <= reduced[r];
            end
        end
    end

endmodule

// File: source/final_adder.sv
module final_adder (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              load_out,
    input  wallace_pkg::row_t rows_in [wallace_pkg::SUM_ROWS],
    output wallace_pkg::row_t product
);
    import wallace_pkg::*;

    row_t sum;

    // Ripple chain, one full adder per bit
    always_comb begin : ripple
        logic x;
        logic y;
        logic c;
        c = 1'b0;
        for (int i = 0; i < PROD_W; i++) begin
            x      = rows_in[0][i];
            y      = rows_in[1][i];
            sum[i] = x ^ y ^ c;
            c      = (x & y) | (c & (x ^ y));
        end
    end

    // Carry out of the top bit is dropped, product fits in PROD_W
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            product <= '0;
        end else if (load_out) begin
            product <= sum;
        end
    end

endmodule

// File: source/wallace_mult_top.sv
module wallace_mult_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  wallace_pkg::operand_t a,
    input  wallace_pkg::operand_t b,
    output logic                out_valid,
    output wallace_pkg::row_t   product,
    output logic                busy
);
    import wallace_pkg::*;

    logic load_pp;
    logic load_mid;
    logic load_sum;
    logic load_out;

    row_t pp_rows  [PP_ROWS];
    row_t mid_rows [MID_ROWS];
    row_t sum_rows [SUM_ROWS];

    pipe_ctrl u_pipe_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .load_pp   (load_pp),
        .load_mid  (load_mid),
        .load_sum  (load_sum),
        .load_out  (load_out),
        .out_valid (out_valid),
        .busy      (busy)
    );

    pp_gen u_pp_gen (
        .clk     (clk),
        .arst_n  (arst_n),
        .load_pp (load_pp),
        .a       (a),
        .b       (b),
        .pp_rows (pp_rows)
    );

    // 16 rows down to 6
    csa_reduce #(
        .IN_ROWS  (PP_ROWS),
        .OUT_ROWS (MID_ROWS)
    ) u_reduce_hi (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (load_mid),
        .rows_in  (pp_rows),
        .rows_out (mid_rows)
    );

    // 6 rows down to the final pair
    csa_reduce #(
        .IN_ROWS  (MID_ROWS),
        .OUT_ROWS (SUM_ROWS)
    ) u_reduce_lo (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (load_sum),
        .rows_in  (mid_rows),
        .rows_out (sum_rows)
    );

    final_adder u_final_adder (
        .clk      (clk),
        .arst_n   (arst_n),
        .load_out (load_out),
        .rows_in  (sum_rows),
        .product  (product)
    );

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the flops
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: dv/wallace_mult_assert.sv
module wallace_mult_assert (
    input logic              clk,
    input logic              arst_n,
    input logic              in_valid,
    input logic              out_valid,
    input wallace_pkg::row_t product,
    input logic              busy
);
    import wallace_pkg::*;

    // Edges since reset release up to the pipeline depth
    int since_rst;
    int fail_cnt = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            since_rst <= 0;
        end else if (since_rst < PIPE_DEPTH) begin
            since_rst <= since_rst + 1;
        end
    end

    valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
        since_rst == PIPE_DEPTH |-> out_valid == $past(in_valid, PIPE_DEPTH))
        else begin
            $error("out_valid is not in_valid delayed by %0d cycles", PIPE_DEPTH);
            fail_cnt++;
        end

    product_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (since_rst != 0 && !out_valid) |-> $stable(product))
        else begin
            $error("product changed without out_valid");
            fail_cnt++;
        end

    // One past sample of in_valid per stage
    busy_flags: assert property (@(posedge clk) disable iff (!arst_n)
        since_rst == PIPE_DEPTH |-> busy == ($past(in_valid, 1) || $past(in_valid, 2)
                                            || $past(in_valid, 3) || $past(in_valid, 4)))
        else begin
            $error("busy does not match the items in flight");
            fail_cnt++;
        end

endmodule

// File: dv/wallace_mult_tb.sv
module wallace_mult_tb;
    import wallace_pkg::*;

    localparam int N_CORNER    = 10;
    localparam int N_STREAM    = 200;
    localparam int N_GAPPED    = 100;
    localparam int HOLD_CYCLES = 20;
    localparam int N_FLUSH     = 3;
    localparam int DRAIN       = PIPE_DEPTH + 4;
    // Gapped test idles at most 3 cycles per pair
    localparam int TEST_CYCLES = N_CORNER * DRAIN + N_STREAM + DRAIN + N_GAPPED * 4 + DRAIN
                               + HOLD_CYCLES + DRAIN + N_FLUSH + 2 * PIPE_DEPTH + 8;
    localparam int CYCLE_LIMIT = 4 * TEST_CYCLES + 100;

    logic     clk;
    logic     rst_n;
    logic     rst_req;
    logic     arst_n;
    logic     in_valid;
    operand_t a;
    operand_t b;
    logic     out_valid;
    row_t     product;
    logic     busy;

    logic [31:0] exp_prod_q [$];
    int          exp_cycle_q [$];
    logic [31:0] lfsr_state   = 32'h89a09439;
    logic [31:0] last_product = '0;
    int          cycle_cnt    = 0;
    int          strobe_cnt   = 0;
    int          checks       = 0;
    int          errors       = 0;
    int          tests        = 0;

    assign arst_n = rst_n & ~rst_req;

    tb_clock_gen #(.PERIOD(10), .RST_CYCLES(2)) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    wallace_mult_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .product   (product),
        .busy      (busy)
    );

    bind wallace_mult_top wallace_mult_assert u_assert (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .product   (product),
        .busy      (busy)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] expected_product(input operand_t x, input operand_t y);
        return {16'h0000, x} * {16'h0000, y};
    endfunction

    // {a, b}
    function automatic logic [31:0] corner_pair(input int idx);
        case (idx)
            0:       return {16'h0000, 16'h1234};
            1:       return {16'hbeef, 16'h0000};
            2:       return {16'h0001, 16'hcafe};
            3:       return {16'h8001, 16'h0001};
            4:       return {16'hffff, 16'hffff};
            5:       return {16'haaaa, 16'h5555};
            6:       return {16'h5555, 16'haaaa};
            7:       return {16'haaaa, 16'haaaa};
            8:       return {16'h5555, 16'h5555};
            default: return {16'hffff, 16'h0001};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Product due PIPE_DEPTH falling edges after this one
    task automatic send_pair(input operand_t x, input operand_t y);
        @(negedge clk);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        exp_prod_q.push_back(expected_product(x, y));
        exp_cycle_q.push_back(cycle_cnt + PIPE_DEPTH);
    endtask

    task automatic send_random();
        logic [31:0] x;
        logic [31:0] y;
        take_bits(OP_W, x);
        take_bits(OP_W, y);
        send_pair(x[OP_W-1:0], y[OP_W-1:0]);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        idle(1);
        while (exp_prod_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        check_value("busy", 32'd0, {31'd0, busy});
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        $display("test %0d %s done with %0d errors", tests, name, errors - err0);
    endtask

    task automatic run_corner_test();
        int          err0;
        logic [31:0] pair;
        err0 = errors;
        for (int i = 0; i < N_CORNER; i++) begin
            pair = corner_pair(i);
            send_pair(pair[31:16], pair[15:0]);
            wait_drain();
        end
        report_test("corner operands", err0);
    endtask

    task automatic run_stream_test();
        int err0;
        err0 = errors;
        for (int i = 0; i < N_STREAM; i++) begin
            send_random();
        end
        wait_drain();
        report_test("back to back stream", err0);
    endtask

    task automatic run_gap_test();
        int          err0;
        int          strobe0;
        logic [31:0] gap;
        err0    = errors;
        strobe0 = strobe_cnt;
        for (int i = 0; i < N_GAPPED; i++) begin
            take_bits(2, gap);
            idle(int'(gap));
            send_random();
        end
        wait_drain();
        check_value("out_valid count", N_GAPPED, strobe_cnt - strobe0);
        report_test("random gaps", err0);
    endtask

    task automatic run_hold_test();
        int err0;
        err0 = errors;
        send_random();
        idle(HOLD_CYCLES);
        wait_drain();
        report_test("product hold", err0);
    endtask

    task automatic run_reset_test();
        int err0;
        int strobe0;
        err0    = errors;
        strobe0 = strobe_cnt;
        for (int i = 0; i < N_FLUSH; i++) begin
            send_random();
        end
        @(negedge clk);
        in_valid = 1'b0;
        rst_req  = 1'b1;
        @(negedge clk);
        check_value("out_valid", 32'd0, {31'd0, out_valid});
        check_value("busy", 32'd0, {31'd0, busy});
        check_value("product", 32'd0, product);
        exp_prod_q.delete();
        exp_cycle_q.delete();
        @(negedge clk);
        rst_req = 1'b0;
        idle(2 * PIPE_DEPTH);
        check_value("out_valid count", strobe0, strobe_cnt);
        report_test("reset in flight", err0);
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // Registered outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!arst_n) begin
            last_product = '0;
        end else begin
            if (out_valid) begin
                strobe_cnt++;
                if (exp_prod_q.size() == 0) begin
                    errors++;
                    $display("ERROR at %0t: out_valid high with no product expected", $time);
                end else begin
                    check_value("product", exp_prod_q.pop_front(), product);
                    check_value("out_valid cycle", exp_cycle_q.pop_front(), cycle_cnt);
                end
            end else begin
                check_value("product held", last_product, product);
            end
            last_product = product;
        end
    end

    initial begin
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        rst_req  = 1'b0;
        wait (rst_n === 1'b1);
        run_corner_test();
        run_stream_test();
        run_gap_test();
        run_hold_test();
        run_reset_test();
        errors = errors + DUT.u_assert.fail_cnt;
        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: all.f
common/wallace_pkg.sv
source/pipe_ctrl.sv
source/pp_gen.sv
wallace/csa_reduce.sv
source/final_adder.sv
source/wallace_mult_top.sv
dv/tb_clock_gen.sv
dv/wallace_mult_assert.sv
dv/wallace_mult_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the Wallace multiplier testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module wallace_mult_tb \
    -f all.f -Mdir "$BUILD_DIR" -o wallace_mult_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/wallace_mult_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
exit 0
